//--- hdl/ovly_blend.sv
// Overlay blender
// Window test, alpha mix, output register, frame done pulse
`timescale 1ns/10ps
`default_nettype none
`include "vidpipe_settings.svh"

module ovly_blend import vidpipe_pkg::*; (
	input  logic                 i_clk,
	input  logic                 i_pxpll_locked,
	input  logic [`VP_LGDIM-1:0] i_hpos,
	input  logic [`VP_LGDIM-1:0] i_vpos,
	input  logic [`VP_LGDIM-1:0] i_ovly_width,
	input  logic [`VP_LGDIM-1:0] i_ovly_height,
	vid_stream_if.sink           bg,
	vid_stream_if.sink           ov,
	output logic                 o_vid_valid,
	input  logic                 i_vid_ready,
	output pixel_t               o_vid_data,
	output logic                 o_vid_hlast,
	output logic                 o_vid_vlast,
	output logic                 o_frame_done
);

	localparam int PW = $bits(pixel_t);

	logic [`VP_LGDIM-1:0] bx, by;
	logic [`VP_LGDIM-1:0] win_h, win_v;
	logic [`VP_LGDIM:0]   win_hend, win_vend;
	logic                 in_win, can_load, fire;
	pixel_t               bg_pix, ov_pix, mix;
	alpha_e               ov_alpha;

	// Floor of the mean of two channels
	function automatic logic [`VP_CW-1:0] half_mix(input logic [`VP_CW-1:0] a,
		input logic [`VP_CW-1:0] b);
		logic [`VP_CW:0] sum;
		sum = {1'b0, a} + {1'b0, b};
		return sum[`VP_CW:1];
	endfunction

	//////////////////////////////
	// Position and window
	//////////////////////////////
	always_ff @(posedge i_clk or negedge i_pxpll_locked) begin
		if (!i_pxpll_locked) begin
			bx       <= '0;
			by       <= '0;
			win_h    <= '0;
			win_v    <= '0;
			win_hend <= '0;
			win_vend <= '0;
		end else begin
			// Window follows the registers until the first pixel moves
			if (bx == '0 && by == '0) begin
				win_h    <= i_hpos;
				win_v    <= i_vpos;
				win_hend <= {1'b0, i_hpos} + i_ovly_width;
				win_vend <= {1'b0, i_vpos} + i_ovly_height;
			end
			if (bg.valid && bg.ready) begin
				if (bg.vlast) begin
					bx <= '0;
					by <= '0;
				end else if (bg.hlast) begin
					bx <= '0;
					by <= by + 1'b1;
				end else begin
					bx <= bx + 1'b1;
				end
			end
		end
	end

	assign in_win = (bx >= win_h) && ({1'b0, bx} < win_hend)
		&& (by >= win_v) && ({1'b0, by} < win_vend);

	//////////////////////////////
	// Handshake and mix
	//////////////////////////////
	// Output register free or draining this cycle
	assign can_load = !o_vid_valid || i_vid_ready;
	// Window pixels need both streams at once
	assign bg.ready = can_load && (!in_win || ov.valid);
	assign ov.ready = can_load && in_win && bg.valid;
	assign fire     = can_load && bg.valid && (!in_win || ov.valid);

	assign bg_pix   = bg.data[PW-1:0];
	assign ov_pix   = ov.data[PW-1:0];
	assign ov_alpha = alpha_e'(ov.data[PW+1 -: 2]);

	always_comb begin
		case (ov_alpha)
		ALPHA_OPAQUE:
			mix = ov_pix;
		ALPHA_HALF_A, ALPHA_HALF_B: begin
			mix.red   = half_mix(ov_pix.red, bg_pix.red);
			mix.green = half_mix(ov_pix.green, bg_pix.green);
			mix.blue  = half_mix(ov_pix.blue, bg_pix.blue);
		end
		default:
			mix = bg_pix;
		endcase
	end

	//////////////////////////////
	// Output stage
	//////////////////////////////
	always_ff @(posedge i_clk or negedge i_pxpll_locked) begin
		if (!i_pxpll_locked) begin
			o_vid_valid  <= 1'b0;
			o_frame_done <= 1'b0;
		end else begin
			if (fire)
				o_vid_valid <= 1'b1;
			else if (i_vid_ready)
				o_vid_valid <= 1'b0;
			// Pulse when the frame's last pixel leaves
			o_frame_done <= o_vid_valid && i_vid_ready && o_vid_vlast;
		end
	end

	always_ff @(posedge i_clk) begin
		if (fire) begin
			o_vid_data  <= in_win ? mix : bg_pix;
			o_vid_hlast <= bg.hlast;
			o_vid_vlast <= bg.vlast;
		end
	end

	// Stalled output holds its pixel and markers
	a_out_hold: assert property (@(posedge i_clk) disable iff (!i_pxpll_locked)
		o_vid_valid && !i_vid_ready |=> o_vid_valid && $stable(o_vid_data)
		&& $stable(o_vid_hlast) && $stable(o_vid_vlast));

	// Overlay markers land on the right and bottom window edges
	a_ov_edges: assert property (@(posedge i_clk) disable iff (!i_pxpll_locked)
		ov.valid && ov.ready |-> ov.hlast == ({1'b0, bx} == win_hend - 1'b1)
		&& ov.vlast == (ov.hlast && {1'b0, by} == win_vend - 1'b1));

endmodule

`default_nettype wire

//--- hdl/ovly_source.sv
// Overlay pixel source
// 16-entry colour map, overlay raster walk, alpha tagging
`timescale 1ns/10ps
`default_nettype none
`include "vidpipe_settings.svh"

module ovly_source import vidpipe_pkg::*; (
	input  logic                   i_clk,
	input  logic                   i_pxpll_locked,
	input  logic                   i_enable,
	input  alpha_e                 i_alpha,
	input  logic [`VP_LGDIM-1:0]   i_width,
	input  logic [`VP_LGDIM-1:0]   i_height,
	input  logic                   i_cmap_we,
	input  logic [`VP_CMAP_LG-1:0] i_cmap_idx,
	input  pixel_t                 i_cmap_color,
	vid_stream_if.source           ov
);

	localparam int CMAP_N = 1 << `VP_CMAP_LG;

	pixel_t               cmap [0:CMAP_N-1];
	logic                 active;
	logic [`VP_LGDIM-1:0] x, y;
	logic [`VP_LGDIM-1:0] w_q, h_q;
	alpha_e               alpha_q;
	pixel_t               pix;
	alpha_e               tag;
	logic                 xfer, line_end, frame_end, start;

	//////////////////////////////
	// Colour map
	//////////////////////////////
	always_ff @(posedge i_clk or negedge i_pxpll_locked) begin
		if (!i_pxpll_locked) begin
			for (int i = 0; i < CMAP_N; i++)
				cmap[i] <= '0;
		end else if (i_cmap_we) begin
			cmap[i_cmap_idx] <= i_cmap_color;
		end
	end

	//////////////////////////////
	// Overlay raster
	//////////////////////////////
	assign xfer      = ov.valid && ov.ready;
	assign line_end  = (x == w_q - 1'b1);
	assign frame_end = line_end && (y == h_q - 1'b1);
	// Empty overlay never starts
	assign start = i_enable && (i_width != '0) && (i_height != '0)
		&& (!active || (xfer && frame_end));

	always_ff @(posedge i_clk or negedge i_pxpll_locked) begin
		if (!i_pxpll_locked) begin
			active  <= 1'b0;
			x       <= '0;
			y       <= '0;
			w_q     <= '0;
			h_q     <= '0;
			alpha_q <= ALPHA_OPAQUE;
		end else if (start) begin
			active  <= 1'b1;
			x       <= '0;
			y       <= '0;
			w_q     <= i_width;
			h_q     <= i_height;
			alpha_q <= i_alpha;
		end else if (xfer) begin
			if (frame_end) begin
				active <= 1'b0;
			end else if (line_end) begin
				x <= '0;
				y <= y + 1'b1;
			end else begin
				x <= x + 1'b1;
			end
		end
	end

	// Column picks the entry, colour zero is transparent
	assign pix = cmap[x[`VP_CMAP_LG-1:0]];
	assign tag = (pix == '0) ? ALPHA_CLEAR : alpha_q;

	assign ov.valid = active;
	assign ov.data  = {tag, pix};
	assign ov.hlast = line_end;
	assign ov.vlast = frame_end;

endmodule

`default_nettype wire

//--- hdl/vid_raster.sv
// Empty frame generator
// Background colour raster with line and frame markers
`timescale 1ns/10ps
`default_nettype none
`include "vidpipe_settings.svh"

module vid_raster import vidpipe_pkg::*; (
	input  logic                 i_clk,
	input  logic                 i_pxpll_locked,
	input  logic                 i_enable,
	input  logic [`VP_LGDIM-1:0] i_width,
	input  logic [`VP_LGDIM-1:0] i_height,
	input  pixel_t               i_color,
	vid_stream_if.source         bg
);

	logic                 active;
	logic [`VP_LGDIM-1:0] x, y;
	logic [`VP_LGDIM-1:0] w_q, h_q;
	pixel_t               color_q;
	logic                 xfer, line_end, frame_end, start;

	assign xfer      = bg.valid && bg.ready;
	assign line_end  = (x == w_q - 1'b1);
	assign frame_end = line_end && (y == h_q - 1'b1);

	// Frame start on leaving idle or on the vlast transfer
	// Zero size keeps the generator idle
	assign start = i_enable && (i_width != '0) && (i_height != '0)
		&& (!active || (xfer && frame_end));

	always_ff @(posedge i_clk or negedge i_pxpll_locked) begin
		if (!i_pxpll_locked) begin
			active <= 1'b0;
			x      <= '0;
			y      <= '0;
			w_q    <= '0;
			h_q    <= '0;
		end else if (start) begin
			active <= 1'b1;
			x      <= '0;
			y      <= '0;
			w_q    <= i_width;
			h_q    <= i_height;
		end else if (xfer) begin
			// Frame ended and no restart, go idle
			if (frame_end) begin
				active <= 1'b0;
			end else if (line_end) begin
				x <= '0;
				y <= y + 1'b1;
			end else begin
				x <= x + 1'b1;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (start)
			color_q <= i_color;
	end

	// Background is always see-through for the blender
	assign bg.valid = active;
	assign bg.data  = {ALPHA_CLEAR, color_q};
	assign bg.hlast = line_end;
	assign bg.vlast = frame_end;

endmodule

`default_nettype wire

//--- hdl/vid_regs.sv
// Wishbone control slave
// Config registers, colour map write strobe, frame counter readback
`timescale 1ns/10ps
`default_nettype none
`include "vidpipe_settings.svh"

module vid_regs import vidpipe_pkg::*; (
	input  logic                    i_clk,
	input  logic                    i_pxpll_locked,
	input  logic                    i_wb_cyc,
	input  logic                    i_wb_stb,
	input  logic                    i_wb_we,
	input  logic [`VP_BUS_AW-1:0]   i_wb_addr,
	input  logic [`VP_BUS_DW-1:0]   i_wb_data,
	input  logic [`VP_BUS_DW/8-1:0] i_wb_sel,
	input  logic                    i_frame_done,
	output logic                    o_wb_ack,
	output logic [`VP_BUS_DW-1:0]   o_wb_data,
	output vid_cfg_t                o_cfg,
	output logic                    o_cmap_we,
	output logic [`VP_CMAP_LG-1:0]  o_cmap_idx,
	output pixel_t                  o_cmap_color
);

	logic                  pre_ack;
	logic [`VP_BUS_DW-1:0] pre_data;
	logic [15:0]           frames;
	logic                  wr, rd, reg_space, cmap_wr;

	assign wr = i_wb_cyc && i_wb_stb && i_wb_we;
	assign rd = i_wb_cyc && i_wb_stb && !i_wb_we;
	// Register window is the low 32 words
	assign reg_space = (i_wb_addr[`VP_BUS_AW-1:5] == '0);
	// Colour map in the upper half, needs all three colour bytes
	assign cmap_wr = wr && i_wb_addr[`VP_BUS_AW-1] && (&i_wb_sel[2:0]);

	//////////////////////////////
	// Register writes
	//////////////////////////////
	always_ff @(posedge i_clk or negedge i_pxpll_locked) begin
		if (!i_pxpll_locked) begin
			o_cfg <= '0;
		end else if (wr && reg_space) begin
			case (reg_addr_e'(i_wb_addr[4:0]))
			REG_CONTROL: begin
				if (i_wb_sel[0])
					o_cfg.enable <= i_wb_data[0];
				if (i_wb_sel[1])
					o_cfg.alpha <= alpha_e'(i_wb_data[15:14]);
			end
			// Two-field registers, each half needs both selects
			REG_SIZE: begin
				if (&i_wb_sel[1:0])
					o_cfg.frame_width <= i_wb_data[0 +: `VP_LGDIM];
				if (&i_wb_sel[3:2])
					o_cfg.frame_height <= i_wb_data[16 +: `VP_LGDIM];
			end
			REG_OVLYSIZE: begin
				if (&i_wb_sel[1:0])
					o_cfg.ovly_width <= i_wb_data[0 +: `VP_LGDIM];
				if (&i_wb_sel[3:2])
					o_cfg.ovly_height <= i_wb_data[16 +: `VP_LGDIM];
			end
			REG_OVLYOFFSET: begin
				if (&i_wb_sel[1:0])
					o_cfg.hpos <= i_wb_data[0 +: `VP_LGDIM];
				if (&i_wb_sel[3:2])
					o_cfg.vpos <= i_wb_data[16 +: `VP_LGDIM];
			end
			// Byte-wide colour lanes
			REG_BGCOLOR: begin
				if (i_wb_sel[0])
					o_cfg.bg_color.blue <= i_wb_data[7:0];
				if (i_wb_sel[1])
					o_cfg.bg_color.green <= i_wb_data[15:8];
				if (i_wb_sel[2])
					o_cfg.bg_color.red <= i_wb_data[23:16];
			end
			default: begin
			end
			endcase
		end
	end

	// Colour map write, one cycle after the bus write
	always_ff @(posedge i_clk or negedge i_pxpll_locked) begin
		if (!i_pxpll_locked)
			o_cmap_we <= 1'b0;
		else
			o_cmap_we <= cmap_wr;
	end

	always_ff @(posedge i_clk) begin
		if (cmap_wr) begin
			o_cmap_idx   <= i_wb_addr[`VP_CMAP_LG-1:0];
			o_cmap_color <= i_wb_data[$bits(pixel_t)-1:0];
		end
	end

	// Finished frames, wraps at 16 bits
	always_ff @(posedge i_clk or negedge i_pxpll_locked) begin
		if (!i_pxpll_locked)
			frames <= '0;
		else if (i_frame_done)
			frames <= frames + 1'b1;
	end

	//////////////////////////////
	// Reads and acknowledge
	//////////////////////////////
	// First stage forms the word, colour map and unknown read as zero
	always_ff @(posedge i_clk) begin
		if (rd) begin
			pre_data <= '0;
			if (reg_space) begin
				case (reg_addr_e'(i_wb_addr[4:0]))
				REG_CONTROL: begin
					pre_data[0]     <= o_cfg.enable;
					pre_data[15:14] <= o_cfg.alpha;
				end
				REG_SIZE: begin
					pre_data[0 +: `VP_LGDIM]  <= o_cfg.frame_width;
					pre_data[16 +: `VP_LGDIM] <= o_cfg.frame_height;
				end
				REG_OVLYSIZE: begin
					pre_data[0 +: `VP_LGDIM]  <= o_cfg.ovly_width;
					pre_data[16 +: `VP_LGDIM] <= o_cfg.ovly_height;
				end
				REG_OVLYOFFSET: begin
					pre_data[0 +: `VP_LGDIM]  <= o_cfg.hpos;
					pre_data[16 +: `VP_LGDIM] <= o_cfg.vpos;
				end
				REG_FRAMES:
					pre_data[15:0] <= frames;
				REG_BGCOLOR:
					pre_data[$bits(pixel_t)-1:0] <= o_cfg.bg_color;
				default: begin
				end
				endcase
			end
		end
	end

	// Second stage lands with the acknowledge
	always_ff @(posedge i_clk) begin
		if (pre_ack)
			o_wb_data <= pre_data;
	end

	// Two-cycle ack, dropping cyc flushes the pipe
	always_ff @(posedge i_clk or negedge i_pxpll_locked) begin
		if (!i_pxpll_locked) begin
			pre_ack  <= 1'b0;
			o_wb_ack <= 1'b0;
		end else if (!i_wb_cyc) begin
			pre_ack  <= 1'b0;
			o_wb_ack <= 1'b0;
		end else begin
			pre_ack  <= i_wb_stb;
			o_wb_ack <= pre_ack;
		end
	end

	// Every ack goes back to a strobe two cycles earlier, with cyc held since
	a_ack_after_cyc: assert property (@(posedge i_clk) disable iff (!i_pxpll_locked)
		o_wb_ack |-> $past(i_wb_cyc) && $past(i_wb_cyc && i_wb_stb, 2));

endmodule

`default_nettype wire

//--- hdl/vid_stream_if.sv
// Video stream interface
// Pixel plus alpha payload, line and frame markers
`timescale 1ns/10ps
`default_nettype none

interface vid_stream_if import vidpipe_pkg::*; ();

	logic valid;
	logic ready;
	// Alpha code in the top two bits, pixel below
	logic [$bits(pixel_t)+1:0] data;
	// Last pixel of a line
	logic hlast;
	// Last pixel of a frame, always with hlast
	logic vlast;

	modport source (
		output valid, data, hlast, vlast,
		input  ready
	);

	modport sink (
		input  valid, data, hlast, vlast,
		output ready
	);

endinterface

`default_nettype wire

//--- hdl/vidpipe_pkg.sv
// Shared types for the video pipeline
// Register map, alpha codes, pixel and configuration structs
`default_nettype none
`include "vidpipe_settings.svh"

package vidpipe_pkg;

	// RGB pixel, red in the top byte
	typedef struct packed {
		logic [`VP_CW-1:0] red;
		logic [`VP_CW-1:0] green;
		logic [`VP_CW-1:0] blue;
	} pixel_t;

	// Overlay alpha codes
	typedef enum logic [1:0] {
		ALPHA_OPAQUE = 2'd0,
		ALPHA_HALF_A = 2'd1,
		ALPHA_HALF_B = 2'd2,
		ALPHA_CLEAR  = 2'd3
	} alpha_e;

	// Control register word addresses
	typedef enum logic [4:0] {
		REG_CONTROL    = 5'h00,
		REG_SIZE       = 5'h08,
		REG_OVLYSIZE   = 5'h0d,
		REG_OVLYOFFSET = 5'h0e,
		REG_FRAMES     = 5'h0f,
		REG_BGCOLOR    = 5'h11
	} reg_addr_e;

	// Live configuration from the register file
	typedef struct packed {
		logic                enable;
		alpha_e              alpha;
		logic [`VP_LGDIM-1:0] frame_width;
		logic [`VP_LGDIM-1:0] frame_height;
		logic [`VP_LGDIM-1:0] ovly_width;
		logic [`VP_LGDIM-1:0] ovly_height;
		logic [`VP_LGDIM-1:0] hpos;
		logic [`VP_LGDIM-1:0] vpos;
		pixel_t              bg_color;
	} vid_cfg_t;

endpackage

`default_nettype wire

//--- hdl/vidpipe_settings.svh
// Global sizing macros for the video pipeline
// Dimension, colour, bus and colour map widths
`ifndef VIDPIPE_SETTINGS_SVH
`define VIDPIPE_SETTINGS_SVH

// Frame and overlay dimension width, up to 4095x4095
`define VP_LGDIM 12

// Bits per colour channel
`define VP_CW 8

// Colour map depth as log2, 16 entries
`define VP_CMAP_LG 4

// Wishbone word address and data widths
`define VP_BUS_AW 10
`define VP_BUS_DW 32

`endif

//--- hdl/vidpipe_top.sv
// Video pipeline top level
// Register file, background raster, overlay source and blender
`timescale 1ns/10ps
`default_nettype none
`include "vidpipe_settings.svh"

module vidpipe_top import vidpipe_pkg::*; (
	input  logic                    i_clk,
	input  logic                    i_pxpll_locked,
	// Wishbone control
	input  logic                    i_wb_cyc,
	input  logic                    i_wb_stb,
	input  logic                    i_wb_we,
	input  logic [`VP_BUS_AW-1:0]   i_wb_addr,
	input  logic [`VP_BUS_DW-1:0]   i_wb_data,
	input  logic [`VP_BUS_DW/8-1:0] i_wb_sel,
	output logic                    o_wb_ack,
	output logic [`VP_BUS_DW-1:0]   o_wb_data,
	// Output video stream
	output logic                    o_vid_valid,
	input  logic                    i_vid_ready,
	output pixel_t                  o_vid_data,
	output logic                    o_vid_hlast,
	output logic                    o_vid_vlast
);

	vid_cfg_t               cfg;
	logic                   cmap_we;
	logic [`VP_CMAP_LG-1:0] cmap_idx;
	pixel_t                 cmap_color;
	logic                   frame_done;

	vid_stream_if bg_stream ();
	vid_stream_if ov_stream ();

	vid_regs u_regs (
		.i_clk          (i_clk),
		.i_pxpll_locked (i_pxpll_locked),
		.i_wb_cyc       (i_wb_cyc),
		.i_wb_stb       (i_wb_stb),
		.i_wb_we        (i_wb_we),
		.i_wb_addr      (i_wb_addr),
		.i_wb_data      (i_wb_data),
		.i_wb_sel       (i_wb_sel),
		.i_frame_done   (frame_done),
		.o_wb_ack       (o_wb_ack),
		.o_wb_data      (o_wb_data),
		.o_cfg          (cfg),
		.o_cmap_we      (cmap_we),
		.o_cmap_idx     (cmap_idx),
		.o_cmap_color   (cmap_color)
	);

	// Background at full frame size
	vid_raster u_raster (
		.i_clk          (i_clk),
		.i_pxpll_locked (i_pxpll_locked),
		.i_enable       (cfg.enable),
		.i_width        (cfg.frame_width),
		.i_height       (cfg.frame_height),
		.i_color        (cfg.bg_color),
		.bg             (bg_stream.source)
	);

	// Overlay at window size
	ovly_source u_ovly (
		.i_clk          (i_clk),
		.i_pxpll_locked (i_pxpll_locked),
		.i_enable       (cfg.enable),
		.i_alpha        (cfg.alpha),
		.i_width        (cfg.ovly_width),
		.i_height       (cfg.ovly_height),
		.i_cmap_we      (cmap_we),
		.i_cmap_idx     (cmap_idx),
		.i_cmap_color   (cmap_color),
		.ov             (ov_stream.source)
	);

	ovly_blend u_blend (
		.i_clk          (i_clk),
		.i_pxpll_locked (i_pxpll_locked),
		.i_hpos         (cfg.hpos),
		.i_vpos         (cfg.vpos),
		.i_ovly_width   (cfg.ovly_width),
		.i_ovly_height  (cfg.ovly_height),
		.bg             (bg_stream.sink),
		.ov             (ov_stream.sink),
		.o_vid_valid    (o_vid_valid),
		.i_vid_ready    (i_vid_ready),
		.o_vid_data     (o_vid_data),
		.o_vid_hlast    (o_vid_hlast),
		.o_vid_vlast    (o_vid_vlast),
		.o_frame_done   (frame_done)
	);

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build the video pipeline testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_vidpipe \
	-f vlog.f \
	-o vsim_tb_vidpipe

out=$(./obj_dir/vsim_tb_vidpipe 2>&1) || {
	echo "$out"
	exit 1
}
echo "$out"

# Exit status follows the pass line
echo "$out" | grep -qx "test passed"

//--- verification/tb_vidpipe.sv
// Testbench for the video pipeline top level
// Wishbone bus tasks, frame receiver, reference frame model
// Register, blending, back-pressure and frame count tests
`timescale 1ns/10ps
`default_nettype none
`include "vidpipe_settings.svh"

module tb_vidpipe import vidpipe_pkg::*; ();

	localparam logic [31:0] SEED = 32'h47cc_8413;
	// Cycle limits for every wait loop
	localparam int ACK_LIMIT   = 16;
	localparam int FRAME_LIMIT = 20000;
	localparam int IDLE_CYCLES = 200;
	// Frame size ranges for the random windows
	localparam int FW_MIN = 8;
	localparam int FW_MAX = 23;
	localparam int FH_MIN = 4;
	localparam int FH_MAX = 11;

	logic                    i_clk;
	logic                    i_pxpll_locked;
	logic                    i_wb_cyc;
	logic                    i_wb_stb;
	logic                    i_wb_we;
	logic [`VP_BUS_AW-1:0]   i_wb_addr;
	logic [`VP_BUS_DW-1:0]   i_wb_data;
	logic [`VP_BUS_DW/8-1:0] i_wb_sel;
	logic                    o_wb_ack;
	logic [`VP_BUS_DW-1:0]   o_wb_data;
	logic                    o_vid_valid;
	logic                    i_vid_ready;
	pixel_t                  o_vid_data;
	logic                    o_vid_hlast;
	logic                    o_vid_vlast;

	// Shadow copy of what the bus wrote
	int          sh_fw, sh_fh, sh_ow, sh_oh, sh_hp, sh_vp;
	logic [23:0] sh_bg;
	logic [1:0]  sh_alpha;
	logic        sh_enable;
	logic [23:0] cmap_m [0:15];

	int    errors, checks, tests_run, tests_ok, test_err_start, frames_seen;
	bit    timed_out;
	string test_name;

	vidpipe_top i_dut (
		.i_clk          (i_clk),
		.i_pxpll_locked (i_pxpll_locked),
		.i_wb_cyc       (i_wb_cyc),
		.i_wb_stb       (i_wb_stb),
		.i_wb_we        (i_wb_we),
		.i_wb_addr      (i_wb_addr),
		.i_wb_data      (i_wb_data),
		.i_wb_sel       (i_wb_sel),
		.o_wb_ack       (o_wb_ack),
		.o_wb_data      (o_wb_data),
		.o_vid_valid    (o_vid_valid),
		.i_vid_ready    (i_vid_ready),
		.o_vid_data     (o_vid_data),
		.o_vid_hlast    (o_vid_hlast),
		.o_vid_vlast    (o_vid_vlast)
	);

	initial begin
		i_clk = 1'b0;
		forever #5 i_clk = ~i_clk;
	end

	//////////////////////////////
	// Checking and bookkeeping
	//////////////////////////////
	task automatic check_value(input string what, input logic [31:0] exp,
		input logic [31:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("error %s %s: expected %h, actual %h", test_name, what, exp, act);
		end
	endtask

	task automatic report_timeout(input string what);
		timed_out = 1'b1;
		$display("%s: gave up waiting, %s", test_name, what);
	endtask

	task automatic begin_test(input string name);
		test_name      = name;
		test_err_start = errors;
	endtask

	task automatic end_test();
		tests_run++;
		if (errors == test_err_start && !timed_out) begin
			tests_ok++;
			$display("%s: ok", test_name);
		end else begin
			$display("%s: %0d errors%s", test_name, errors - test_err_start,
				timed_out ? ", timed out" : "");
		end
	endtask

	function automatic int rnd(input int lo, input int hi);
		return lo + int'($urandom % (hi - lo + 1));
	endfunction

	//////////////////////////////
	// Wishbone access
	//////////////////////////////
	// One strobe, then hold cyc until the ack
	task automatic bus_cycle(input logic we, input logic [`VP_BUS_AW-1:0] addr,
		input logic [31:0] wdata, input logic [3:0] sel, output logic [31:0] rdata);
		int waited;
		rdata = '0;
		if (timed_out)
			return;
		@(negedge i_clk);
		i_wb_cyc  = 1'b1;
		i_wb_stb  = 1'b1;
		i_wb_we   = we;
		i_wb_addr = addr;
		i_wb_data = wdata;
		i_wb_sel  = sel;
		@(negedge i_clk);
		i_wb_stb = 1'b0;
		waited   = 1;
		while (!o_wb_ack && waited < ACK_LIMIT) begin
			@(negedge i_clk);
			waited++;
		end
		if (!o_wb_ack)
			report_timeout($sformatf("no acknowledge for address %h", addr));
		else
			check_value("ack delay", 32'd2, 32'(waited));
		rdata    = o_wb_data;
		i_wb_cyc = 1'b0;
		i_wb_we  = 1'b0;
	endtask

	// Bus write plus the shadow update by the register rules
	task automatic write_reg(input reg_addr_e addr, input logic [31:0] data,
		input logic [3:0] sel);
		logic [31:0] rd;
		bus_cycle(1'b1, {5'd0, addr}, data, sel, rd);
		case (addr)
		REG_CONTROL: begin
			if (sel[0])
				sh_enable = data[0];
			if (sel[1])
				sh_alpha = data[15:14];
		end
		REG_SIZE: begin
			if (&sel[1:0])
				sh_fw = int'(data[11:0]);
			if (&sel[3:2])
				sh_fh = int'(data[27:16]);
		end
		REG_OVLYSIZE: begin
			if (&sel[1:0])
				sh_ow = int'(data[11:0]);
			if (&sel[3:2])
				sh_oh = int'(data[27:16]);
		end
		REG_OVLYOFFSET: begin
			if (&sel[1:0])
				sh_hp = int'(data[11:0]);
			if (&sel[3:2])
				sh_vp = int'(data[27:16]);
		end
		// Only written with all lanes
		REG_BGCOLOR:
			sh_bg = data[23:0];
		default: begin
		end
		endcase
	endtask

	function automatic logic [31:0] expected_reg(input reg_addr_e addr);
		case (addr)
		REG_CONTROL:    return {16'd0, sh_alpha, 13'd0, sh_enable};
		REG_SIZE:       return {4'd0, 12'(sh_fh), 4'd0, 12'(sh_fw)};
		REG_OVLYSIZE:   return {4'd0, 12'(sh_oh), 4'd0, 12'(sh_ow)};
		REG_OVLYOFFSET: return {4'd0, 12'(sh_vp), 4'd0, 12'(sh_hp)};
		REG_FRAMES:     return {16'd0, 16'(frames_seen)};
		REG_BGCOLOR:    return {8'd0, sh_bg};
		default:        return 32'd0;
		endcase
	endfunction

	task automatic read_check(input logic [`VP_BUS_AW-1:0] addr, input logic [31:0] exp,
		input string what);
		logic [31:0] rd;
		bus_cycle(1'b0, addr, 32'd0, 4'hf, rd);
		check_value(what, exp, rd);
	endtask

	// Colour map lives at address bit 9
	task automatic write_cmap(input int idx, input logic [23:0] color);
		logic [31:0] rd;
		bus_cycle(1'b1, 10'h200 | 10'(idx), {8'hff, color}, 4'b0111, rd);
		cmap_m[idx] = color;
	endtask

	task automatic set_control(input logic [1:0] alpha, input logic en);
		write_reg(REG_CONTROL, {16'd0, alpha, 13'd0, en}, 4'hf);
	endtask

	//////////////////////////////
	// Reference model
	//////////////////////////////
	// Expected output pixel at column x, row y
	function automatic logic [23:0] model_pixel(input int x, input int y);
		logic [23:0] c;
		logic [8:0]  r, g, b;
		if (x < sh_hp || x >= sh_hp + sh_ow || y < sh_vp || y >= sh_vp + sh_oh)
			return sh_bg;
		c = cmap_m[(x - sh_hp) % 16];
		// Colour zero is see-through
		if (c == 24'd0 || sh_alpha == 2'd3)
			return sh_bg;
		if (sh_alpha == 2'd0)
			return c;
		r = {1'b0, c[23:16]} + {1'b0, sh_bg[23:16]};
		g = {1'b0, c[15:8]} + {1'b0, sh_bg[15:8]};
		b = {1'b0, c[7:0]} + {1'b0, sh_bg[7:0]};
		return {r[8:1], g[8:1], b[8:1]};
	endfunction

	//////////////////////////////
	// Stimulus helpers
	//////////////////////////////
	task automatic random_cmap();
		logic [23:0] c;
		for (int i = 0; i < 16; i++) begin
			c = 24'($urandom);
			// About one entry in four transparent
			if ($urandom % 4 == 0)
				c = 24'd0;
			write_cmap(i, c);
		end
	endtask

	// Frame plus a window that fits inside it, overlay at least 2 wide
	task automatic random_window();
		int fw, fh, ow, oh;
		fw = rnd(FW_MIN, FW_MAX);
		fh = rnd(FH_MIN, FH_MAX);
		ow = rnd(2, fw);
		oh = rnd(1, fh);
		write_reg(REG_SIZE, {4'd0, 12'(fh), 4'd0, 12'(fw)}, 4'hf);
		write_reg(REG_OVLYSIZE, {4'd0, 12'(oh), 4'd0, 12'(ow)}, 4'hf);
		write_reg(REG_OVLYOFFSET, {4'd0, 12'(rnd(0, fh - oh)), 4'd0, 12'(rnd(0, fw - ow))},
			4'hf);
		write_reg(REG_BGCOLOR, $urandom, 4'hf);
	endtask

	// Collect one frame, compare each pixel, watch held outputs under stall
	task automatic receive_frame(input bit random_ready);
		int          got, cycles, x, y;
		bit          done, stalled;
		logic [25:0] held;
		got     = 0;
		cycles  = 0;
		done    = 0;
		stalled = 0;
		held    = '0;
		if (timed_out)
			return;
		while (!done && cycles < FRAME_LIMIT) begin
			@(negedge i_clk);
			cycles++;
			if (stalled) begin
				check_value("held valid", 32'd1, {31'd0, o_vid_valid});
				check_value("held output", {6'd0, held},
					{6'd0, o_vid_hlast, o_vid_vlast, o_vid_data});
			end
			i_vid_ready = random_ready ? 1'($urandom % 2) : 1'b1;
			stalled     = o_vid_valid && !i_vid_ready;
			held        = {o_vid_hlast, o_vid_vlast, o_vid_data};
			if (o_vid_valid && i_vid_ready) begin
				x = got % sh_fw;
				y = got / sh_fw;
				check_value($sformatf("pixel %0d,%0d", x, y), {8'd0, model_pixel(x, y)},
					{8'd0, o_vid_data});
				check_value($sformatf("markers %0d,%0d", x, y),
					{30'd0, x == sh_fw - 1, got == sh_fw * sh_fh - 1},
					{30'd0, o_vid_hlast, o_vid_vlast});
				got++;
				if (o_vid_vlast) begin
					done = 1;
					frames_seen++;
				end
			end
		end
		if (!done)
			report_timeout("frame never finished");
		else
			check_value("frame pixel count", 32'(sh_fw * sh_fh), 32'(got));
		// Park the output after the last transfer
		@(negedge i_clk);
		i_vid_ready = 1'b0;
	endtask

	// Start a frame with the output stalled, clear enable, then take it
	task automatic run_one_frame(input logic [1:0] alpha, input bit random_ready);
		set_control(alpha, 1'b1);
		set_control(alpha, 1'b0);
		receive_frame(random_ready);
	endtask

	//////////////////////////////
	// Tests
	//////////////////////////////
	task automatic register_readback();
		reg_addr_e addr;
		int        pick;
		logic [3:0] sel;
		begin_test("register readback");
		read_check({5'd0, REG_SIZE}, 32'd0, "size after reset");
		repeat (12) begin
			pick = rnd(0, 2);
			addr = (pick == 0) ? REG_SIZE : (pick == 1) ? REG_OVLYSIZE : REG_OVLYOFFSET;
			// Half the writes use partial selects
			sel  = ($urandom % 2 == 0) ? 4'hf : 4'($urandom);
			write_reg(addr, $urandom, sel);
			read_check({5'd0, addr}, expected_reg(addr), $sformatf("readback sel %h", sel));
		end
		write_reg(REG_BGCOLOR, $urandom, 4'hf);
		read_check({5'd0, REG_BGCOLOR}, expected_reg(REG_BGCOLOR), "background colour");
		// Enable stays off
		write_reg(REG_CONTROL, $urandom & 32'hffff_fffe, 4'hf);
		read_check({5'd0, REG_CONTROL}, expected_reg(REG_CONTROL), "control");
		read_check(10'h200 | 10'(rnd(0, 15)), 32'd0, "colour map read");
		end_test();
	endtask

	task automatic background_frame();
		begin_test("background frame");
		write_reg(REG_OVLYSIZE, 32'd0, 4'hf);
		write_reg(REG_OVLYOFFSET, 32'd0, 4'hf);
		// At least two pixels so the frame cannot restart before enable drops
		write_reg(REG_SIZE, {4'd0, 12'(rnd(1, 8)), 4'd0, 12'(rnd(2, 17))}, 4'hf);
		write_reg(REG_BGCOLOR, $urandom, 4'hf);
		run_one_frame(2'd0, 1'b0);
		end_test();
	endtask

	task automatic overlay_frame(input string name, input logic [1:0] alpha,
		input bit random_ready);
		begin_test(name);
		random_cmap();
		random_window();
		run_one_frame(alpha, random_ready);
		end_test();
	endtask

	task automatic count_and_stop();
		int count, idle, cycles;
		logic last_v;
		begin_test("frame counting");
		write_reg(REG_OVLYSIZE, 32'd0, 4'hf);
		write_reg(REG_SIZE, {4'd0, 12'(rnd(2, 6)), 4'd0, 12'(rnd(4, 12))}, 4'hf);
		write_reg(REG_BGCOLOR, $urandom, 4'hf);
		set_control(sh_alpha, 1'b1);
		repeat (3)
			receive_frame(1'b0);
		// Output is parked mid frame while enable drops
		set_control(sh_alpha, 1'b0);
		count  = 0;
		idle   = 0;
		cycles = 0;
		last_v = 1'b0;
		while (!timed_out && idle < IDLE_CYCLES && cycles < FRAME_LIMIT) begin
			@(negedge i_clk);
			cycles++;
			i_vid_ready = 1'b1;
			if (o_vid_valid) begin
				count++;
				idle   = 0;
				last_v = o_vid_vlast;
			end else begin
				idle++;
			end
		end
		if (idle < IDLE_CYCLES) begin
			report_timeout("output never went idle after enable was cleared");
		end else begin
			// The frame in flight still completes
			frames_seen++;
			check_value("pixels after stop", 32'(sh_fw * sh_fh), 32'(count));
			check_value("stop on vlast", 32'd1, {31'd0, last_v});
		end
		@(negedge i_clk);
		i_vid_ready = 1'b0;
		read_check({5'd0, REG_FRAMES}, expected_reg(REG_FRAMES), "frame count");
		end_test();
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////
	initial begin
		i_pxpll_locked = 1'b0;
		i_wb_cyc       = 1'b0;
		i_wb_stb       = 1'b0;
		i_wb_we        = 1'b0;
		i_wb_addr      = '0;
		i_wb_data      = '0;
		i_wb_sel       = '0;
		i_vid_ready    = 1'b0;
		errors         = 0;
		checks         = 0;
		tests_run      = 0;
		tests_ok       = 0;
		frames_seen    = 0;
		timed_out      = 1'b0;
		sh_fw          = 0;
		sh_fh          = 0;
		sh_ow          = 0;
		sh_oh          = 0;
		sh_hp          = 0;
		sh_vp          = 0;
		sh_bg          = '0;
		sh_alpha       = '0;
		sh_enable      = 1'b0;
		for (int i = 0; i < 16; i++)
			cmap_m[i] = '0;
		void'($urandom(SEED));

		repeat (10) @(negedge i_clk);
		i_pxpll_locked = 1'b1;

		register_readback();
		if (!timed_out)
			background_frame();
		if (!timed_out)
			overlay_frame("opaque overlay", 2'd0, 1'b0);
		if (!timed_out)
			overlay_frame("half blending", 2'd1, 1'b0);
		if (!timed_out)
			overlay_frame("back-pressure", 2'(rnd(0, 3)), 1'b1);
		if (!timed_out)
			count_and_stop();

		$display("summary: %0d tests, %0d ok, %0d checks, %0d errors",
			tests_run, tests_ok, checks, errors);
		if (errors == 0 && !timed_out)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+hdl
hdl/vidpipe_pkg.sv
hdl/vid_stream_if.sv
hdl/vid_regs.sv
hdl/vid_raster.sv
hdl/ovly_source.sv
hdl/ovly_blend.sv
hdl/vidpipe_top.sv
verification/tb_vidpipe.sv
